// ==== Makefile ====
SRCS = hw/common.sv hw/decompressor.sv hw/fetch_aligner.sv hw/fetch_frontend.sv \
       bench/fetch_checker.sv bench/tb_fetch_frontend.sv

.PHONY: all run clean

all: obj_dir/Vtb_fetch_frontend

obj_dir/Vtb_fetch_frontend: $(SRCS) tb.f
	verilator --binary --timing --assert -f tb.f --top-module tb_fetch_frontend \
		-o Vtb_fetch_frontend

run: obj_dir/Vtb_fetch_frontend
	obj_dir/Vtb_fetch_frontend | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/fetch_checker.sv ====
// Testbench checker for the fetch front end, models the parcel stream and compares every issue
`timescale 1ns/1ps

module fetch_checker (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           fetch_valid,
  input  common::word_t  fetch_word,
  input  logic           fetch_stall,
  input  logic           issue_valid,
  input  common::issue_t issue,
  input  logic           end_of_test,
  output logic           drained,
  output int             mismatch_count,
  output int             other_count,
  output int             issued_count
);
  import common::*;

  halfword_t   model_q [$];
  pc_t         model_pc;
  logic [31:0] exp_instr;
  logic        exp_compressed;
  logic [31:0] pc_step;
  int          stall_cycles;
  int          accepted_halfwords;
  int          issued_halfwords;
  logic        final_done;

  // RV32I form of one parcel, built field by field from the RVC rules
  function automatic logic [31:0] expand_parcel(input logic [15:0] c);
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  p_hi;
    logic [4:0]  p_lo;
    logic [11:0] imm6;
    logic [11:0] uoff;
    logic [12:0] boff;
    logic [19:0] upper;
    logic [31:0] r;
    rd    = c[11:7];
    rs2   = c[6:2];
    p_hi  = 5'd8 + {2'b00, c[9:7]};
    p_lo  = 5'd8 + {2'b00, c[4:2]};
    imm6  = {{6{c[12]}}, c[12], c[6:2]};
    uoff  = {5'd0, c[5], c[12:10], c[6], 2'b00};
    boff  = {{4{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
    upper = {{14{c[12]}}, c[12], c[6:2]};
    r     = {16'h0000, c};
    case (c[1:0])
      2'b00: begin
        case (c[15:13])
          3'b010: r = {uoff, p_hi, 3'b010, p_lo, op_load};
          3'b110: r = {uoff[11:5], p_lo, p_hi, 3'b010, uoff[4:0], op_store};
          default: ;
        endcase
      end
      2'b01: begin
        case (c[15:13])
          3'b000: r = {imm6, rd, 3'b000, rd, op_imm};
          3'b010: r = {imm6, 5'd0, 3'b000, rd, op_imm};
          3'b011: r = {upper, rd, op_lui};
          3'b100: begin
            case (c[11:10])
              2'b00: r = {7'b0000000, c[6:2], p_hi, 3'b101, p_hi, op_imm};
              2'b01: r = {7'b0100000, c[6:2], p_hi, 3'b101, p_hi, op_imm};
              2'b10: r = {imm6, p_hi, 3'b111, p_hi, op_imm};
              default: begin
                if (!c[12]) begin
                  case (c[6:5])
                    2'b00: r = {7'b0100000, p_lo, p_hi, 3'b000, p_hi, op_op};
                    2'b01: r = {7'b0000000, p_lo, p_hi, 3'b100, p_hi, op_op};
                    2'b10: r = {7'b0000000, p_lo, p_hi, 3'b110, p_hi, op_op};
                    default: r = {7'b0000000, p_lo, p_hi, 3'b111, p_hi, op_op};
                  endcase
                end
              end
            endcase
          end
          3'b110: r = {boff[12], boff[10:5], 5'd0, p_hi, 3'b000, boff[4:1], boff[11], op_branch};
          3'b111: r = {boff[12], boff[10:5], 5'd0, p_hi, 3'b001, boff[4:1], boff[11], op_branch};
          default: ;
        endcase
      end
      2'b10: begin
        if (c[15:13] == 3'b000) begin
          r = {7'b0000000, c[6:2], rd, 3'b001, rd, op_imm};
        end else if (c[15:13] == 3'b100) begin
          // MV reads x0, ADD reads rd
          r = {7'b0000000, rs2, (c[12] ? rd : 5'd0), 3'b000, rd, op_op};
        end
      end
      default: ;
    endcase
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      $display("mismatch at %0d ns: %s expected %h got %h", $time, name, exp, got);
      mismatch_count++;
    end
  endtask

  task automatic report(input string what);
    $display("Error at %0d ns: %s", $time, what);
    other_count++;
  endtask

  initial begin
    drained            = 1'b1;
    mismatch_count     = 0;
    other_count        = 0;
    issued_count       = 0;
    stall_cycles       = 0;
    accepted_halfwords = 0;
    issued_halfwords   = 0;
    final_done         = 1'b0;
    model_pc           = reset_pc;
  end

  // Everything is stable at the falling edge
  always @(negedge clk) begin
    if (!arst_n) begin
      if (issue_valid || fetch_stall) begin
        report("issue_valid or fetch_stall high during reset");
      end
      model_q.delete();
      model_pc = reset_pc;
    end else begin
      if (fetch_stall) begin
        stall_cycles++;
      end
      if (issue_valid) begin
        if (model_q.size() == 0) begin
          report("instruction issued with no accepted parcel left");
        end else if (model_q[0][1:0] == 2'b11 && model_q.size() < 2) begin
          report("32-bit instruction issued before its upper half was accepted");
        end else begin
          if (model_q[0][1:0] == 2'b11) begin
            exp_instr      = {model_q[1], model_q[0]};
            exp_compressed = 1'b0;
            pc_step        = 32'd4;
            void'(model_q.pop_front());
            void'(model_q.pop_front());
          end else begin
            exp_instr      = expand_parcel(model_q[0]);
            exp_compressed = 1'b1;
            pc_step        = 32'd2;
            void'(model_q.pop_front());
          end
          check_value("issue.instr", exp_instr, issue.instr);
          check_value("issue.pc", model_pc, issue.pc);
          check_value("issue.compressed", {31'b0, exp_compressed}, {31'b0, issue.compressed});
          model_pc         = model_pc + pc_step;
          issued_count++;
          issued_halfwords = issued_halfwords + (exp_compressed ? 1 : 2);
        end
      end
      // Parcels still held once this cycle's issue is gone and before the offered word lands
      check_value("fetch_stall", {31'b0, model_q.size() >= stall_level}, {31'b0, fetch_stall});
      if (fetch_valid) begin
        if (fetch_stall) begin
          report("word offered while fetch_stall was high");
        end
        model_q.push_back(fetch_word[15:0]);
        model_q.push_back(fetch_word[31:16]);
        accepted_halfwords = accepted_halfwords + 2;
      end
      if (end_of_test && !final_done) begin
        final_done = 1'b1;
        if (stall_cycles == 0) begin
          report("fetch_stall never rose under heavy offering");
        end
        // Only a lone lower half of a 32-bit instruction may stay behind
        if (accepted_halfwords - issued_halfwords > 1 ||
            (model_q.size() == 1 && model_q[0][1:0] != 2'b11)) begin
          $display("Error at %0d ns: %0d halfwords accepted but only %0d issued",
                   $time, accepted_halfwords, issued_halfwords);
          other_count++;
        end
      end
    end
    drained = (model_q.size() == 0) || (model_q.size() == 1 && model_q[0][1:0] == 2'b11);
  end

endmodule

// ==== bench/tb_fetch_frontend.sv ====
// Testbench top for the fetch front end, sends seeded random fetch words and reports the result
`timescale 1ns/1ps

module tb_fetch_frontend;
  import common::*;

  localparam int clk_period    = 20;
  localparam int words_to_send = 500;
  localparam int watchdog_cycles = words_to_send * 4 + 50;

  logic      clk;
  logic      arst_n;
  logic      fetch_valid;
  word_t     fetch_word;
  logic      fetch_stall;
  logic      issue_valid;
  issue_t    issue;
  logic      end_of_test;
  logic      drained;
  int        mismatch_count;
  int        other_count;
  int        issued_count;
  int        seed;
  int        words_sent;
  word_t     next;
  logic [31:0] r;
  // Parcels waiting to be packed into words
  halfword_t stream_q [$];

  fetch_frontend u_dut (
    .clk         (clk),
    .arst_n      (arst_n),
    .fetch_valid (fetch_valid),
    .fetch_word  (fetch_word),
    .fetch_stall (fetch_stall),
    .issue_valid (issue_valid),
    .issue       (issue)
  );

  fetch_checker u_chk (
    .clk            (clk),
    .arst_n         (arst_n),
    .fetch_valid    (fetch_valid),
    .fetch_word     (fetch_word),
    .fetch_stall    (fetch_stall),
    .issue_valid    (issue_valid),
    .issue          (issue),
    .end_of_test    (end_of_test),
    .drained        (drained),
    .mismatch_count (mismatch_count),
    .other_count    (other_count),
    .issued_count   (issued_count)
  );

  // One of the listed RVC forms with random fields
  function automatic halfword_t compressed_form(input int form, input logic [15:0] f);
    case (form)
      0:  return {3'b010, f[12:2], 2'b00};
      1:  return {3'b110, f[12:2], 2'b00};
      2:  return {3'b000, f[12:2], 2'b01};
      3:  return {3'b010, f[12:2], 2'b01};
      4:  return {3'b011, f[12:2], 2'b01};
      5:  return {3'b100, f[12], 2'b00, f[9:2], 2'b01};
      6:  return {3'b100, f[12], 2'b01, f[9:2], 2'b01};
      7:  return {3'b100, f[12], 2'b10, f[9:2], 2'b01};
      8:  return {6'b100011, f[9:7], 2'b00, f[4:2], 2'b01};
      9:  return {6'b100011, f[9:7], 2'b01, f[4:2], 2'b01};
      10: return {6'b100011, f[9:7], 2'b10, f[4:2], 2'b01};
      11: return {6'b100011, f[9:7], 2'b11, f[4:2], 2'b01};
      12: return {3'b110, f[12:2], 2'b01};
      13: return {3'b111, f[12:2], 2'b01};
      14: return {3'b000, f[12:2], 2'b10};
      15: return {4'b1000, f[11:2], 2'b10};
      default: return {4'b1001, f[11:2], 2'b10};
    endcase
  endfunction

  // Mix of listed forms, other 16-bit parcels and full 32-bit instructions
  task automatic add_instruction();
    logic [31:0] pick;
    logic [31:0] bits;
    pick = $random(seed);
    bits = $random(seed);
    if (pick % 32'd100 < 32'd60) begin
      stream_q.push_back(compressed_form(int'(pick[31:8] % 24'd17), bits[15:0]));
    end else if (pick % 32'd100 < 32'd75) begin
      if (bits[1:0] == 2'b11) begin
        bits[1] = 1'b0;
      end
      stream_q.push_back(bits[15:0]);
    end else begin
      bits[1:0] = 2'b11;
      stream_q.push_back(bits[15:0]);
      stream_q.push_back(bits[31:16]);
    end
  endtask

  task automatic pack_word(output word_t w);
    while (stream_q.size() < 2) begin
      add_instruction();
    end
    w = {stream_q[1], stream_q[0]};
    void'(stream_q.pop_front());
    void'(stream_q.pop_front());
  endtask

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("Timeout after %0d cycles with %0d of %0d words sent, %0d instructions issued",
             watchdog_cycles, words_sent, words_to_send, issued_count);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    seed        = 24044;
    words_sent  = 0;
    arst_n      = 1'b0;
    fetch_valid = 1'b0;
    fetch_word  = '0;
    end_of_test = 1'b0;
    repeat (2) @(posedge clk);
    #2 arst_n = 1'b1;
    while (words_sent < words_to_send) begin
      @(posedge clk);
      #2;
      fetch_valid = 1'b0;
      r = $random(seed);
      if (!fetch_stall && r[1:0] != 2'b00) begin
        pack_word(next);
        fetch_word  = next;
        fetch_valid = 1'b1;
        words_sent++;
      end
    end
    @(posedge clk);
    #2 fetch_valid = 1'b0;
    wait (drained);
    // A few idle cycles catch any extra issue
    repeat (4) @(posedge clk);
    end_of_test = 1'b1;
    repeat (2) @(posedge clk);
    $display("Sent %0d words, issued %0d instructions, %0d mismatches, %0d other errors",
             words_sent, issued_count, mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== hw/common.sv ====
// Shared widths, instruction formats and constants of the fetch front end, imported by each module
package common;

  // One instruction parcel
  typedef logic [15:0] halfword_t;

  // One fetch word from the source
  typedef logic [31:0] word_t;

  typedef logic [31:0] pc_t;

  // RV32 instruction in R-format field order
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instruction_type;

  // Registered output of the front end
  typedef struct packed {
    instruction_type instr;
    pc_t             pc;
    logic            compressed;
  } issue_t;

  // Aligner to top level, upper half of bits is zero for a 16-bit parcel
  typedef struct packed {
    word_t bits;
    pc_t   pc;
    logic  compressed;
  } raw_instr_t;

  // Address of the first parcel after reset
  localparam pc_t reset_pc = 32'h0000_0000;

  // Aligner buffer depth in halfwords
  localparam int buf_halfwords = 4;

  // Fill level that raises fetch_stall
  localparam int stall_level = 3;

  // RV32I major opcodes
  localparam logic [6:0] op_op     = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_lui    = 7'b0110111;

endpackage

// ==== hw/decompressor.sv ====
// Combinational expansion of one RVC parcel into its RV32I encoding, used by the fetch front end
`timescale 1ns/1ps

module decompressor (
  input  common::halfword_t       cinstr,
  output common::instruction_type expanded
);
  import common::*;

  // x8..x15 from a 3-bit register field
  function automatic logic [4:0] creg(input logic [2:0] r);
    return {2'b01, r};
  endfunction

  function automatic instruction_type enc_r(input logic [6:0] funct7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] funct3,
                                            input logic [4:0] rd);
    instruction_type ins;
    ins.funct7 = funct7;
    ins.rs2    = rs2;
    ins.rs1    = rs1;
    ins.funct3 = funct3;
    ins.rd     = rd;
    ins.opcode = op_op;
    return ins;
  endfunction

  function automatic instruction_type enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] funct3, input logic [4:0] rd,
                                            input logic [6:0] opcode);
    instruction_type ins;
    ins.funct7 = imm[11:5];
    ins.rs2    = imm[4:0];
    ins.rs1    = rs1;
    ins.funct3 = funct3;
    ins.rd     = rd;
    ins.opcode = opcode;
    return ins;
  endfunction

  function automatic instruction_type enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] funct3);
    instruction_type ins;
    ins.funct7 = imm[11:5];
    ins.rs2    = rs2;
    ins.rs1    = rs1;
    ins.funct3 = funct3;
    ins.rd     = imm[4:0];
    ins.opcode = op_store;
    return ins;
  endfunction

  // Branch against x0, imm is the byte offset without bit 0
  function automatic instruction_type enc_b(input logic [12:1] imm, input logic [4:0] rs1,
                                            input logic [2:0] funct3);
    instruction_type ins;
    ins.funct7 = {imm[12], imm[10:5]};
    ins.rs2    = 5'd0;
    ins.rs1    = rs1;
    ins.funct3 = funct3;
    ins.rd     = {imm[4:1], imm[11]};
    ins.opcode = op_branch;
    return ins;
  endfunction

  function automatic instruction_type enc_u(input logic [19:0] imm, input logic [4:0] rd);
    instruction_type ins;
    {ins.funct7, ins.rs2, ins.rs1, ins.funct3} = imm;
    ins.rd     = rd;
    ins.opcode = op_lui;
    return ins;
  endfunction

  // Immediates
  logic [11:0] imm_ci;
  logic [11:0] imm_mem;
  logic [12:1] imm_br;
  logic [19:0] imm_lui;
  logic [11:0] shamt_l;
  logic [11:0] shamt_a;

  // Register fields
  logic [4:0] rd_full;
  logic [4:0] rs2_full;
  logic [4:0] rd_p;
  logic [4:0] rs2_p;

  assign imm_ci  = {{6{cinstr[12]}}, cinstr[12], cinstr[6:2]};
  // Word offset, zero-extended
  assign imm_mem = {5'b00000, cinstr[5], cinstr[12:10], cinstr[6], 2'b00};
  assign imm_br  = {{4{cinstr[12]}}, cinstr[12], cinstr[6:5], cinstr[2], cinstr[11:10],
                    cinstr[4:3]};
  assign imm_lui = {{14{cinstr[12]}}, cinstr[12], cinstr[6:2]};
  assign shamt_l = {7'b0000000, cinstr[6:2]};
  assign shamt_a = {7'b0100000, cinstr[6:2]};

  assign rd_full  = cinstr[11:7];
  assign rs2_full = cinstr[6:2];
  assign rd_p     = creg(cinstr[9:7]);
  assign rs2_p    = creg(cinstr[4:2]);

  // Fields: funct3 _ b12 _ b11:10 _ b9:7 _ b6:5 _ b4:2 _ quadrant
  always_comb begin
    casez (cinstr)
      // Quadrant 0
      16'b010_?_??_???_??_???_00: expanded = enc_i(imm_mem, rd_p, 3'b010, rs2_p, op_load);
      16'b110_?_??_???_??_???_00: expanded = enc_s(imm_mem, rs2_p, rd_p, 3'b010);

      // Quadrant 1
      16'b000_?_??_???_??_???_01: expanded = enc_i(imm_ci, rd_full, 3'b000, rd_full, op_imm);
      16'b010_?_??_???_??_???_01: expanded = enc_i(imm_ci, 5'd0, 3'b000, rd_full, op_imm);
      16'b011_?_??_???_??_???_01: expanded = enc_u(imm_lui, rd_full);
      16'b100_?_00_???_??_???_01: expanded = enc_i(shamt_l, rd_p, 3'b101, rd_p, op_imm);
      16'b100_?_01_???_??_???_01: expanded = enc_i(shamt_a, rd_p, 3'b101, rd_p, op_imm);
      16'b100_?_10_???_??_???_01: expanded = enc_i(imm_ci, rd_p, 3'b111, rd_p, op_imm);
      16'b100_0_11_???_00_???_01: expanded = enc_r(7'b0100000, rs2_p, rd_p, 3'b000, rd_p);
      16'b100_0_11_???_01_???_01: expanded = enc_r(7'b0000000, rs2_p, rd_p, 3'b100, rd_p);
      16'b100_0_11_???_10_???_01: expanded = enc_r(7'b0000000, rs2_p, rd_p, 3'b110, rd_p);
      16'b100_0_11_???_11_???_01: expanded = enc_r(7'b0000000, rs2_p, rd_p, 3'b111, rd_p);
      16'b110_?_??_???_??_???_01: expanded = enc_b(imm_br, rd_p, 3'b000);
      16'b111_?_??_???_??_???_01: expanded = enc_b(imm_br, rd_p, 3'b001);

      // Quadrant 2
      16'b000_?_??_???_??_???_10: expanded = enc_i(shamt_l, rd_full, 3'b001, rd_full, op_imm);
      16'b100_0_??_???_??_???_10: expanded = enc_r(7'b0000000, rs2_full, 5'd0, 3'b000, rd_full);
      16'b100_1_??_???_??_???_10: begin
        expanded = enc_r(7'b0000000, rs2_full, rd_full, 3'b000, rd_full);
      end

      // Anything else goes out as is
      default: expanded = instruction_type'({16'h0000, cinstr});
    endcase
  end

endmodule

// ==== hw/fetch_aligner.sv ====
// Breaks fetch words into parcels, finds 16/32-bit instruction boundaries and tracks their PC
`timescale 1ns/1ps

module fetch_aligner (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               fetch_valid,
  input  common::word_t      fetch_word,
  output logic               fetch_stall,
  output logic               raw_valid,
  output common::raw_instr_t raw
);
  import common::*;

  // Parcel buffer, entry 0 is the head
  halfword_t buf_q [buf_halfwords];
  halfword_t buf_d [buf_halfwords];

  logic [2:0] count_q;
  logic [2:0] count_d;
  logic [2:0] remaining;
  logic [1:0] consume;
  logic       head_is32;
  pc_t        pc_q;

  // A 32-bit instruction needs both of its halves in the buffer
  assign head_is32 = (buf_q[0][1:0] == 2'b11);
  assign raw_valid = (count_q != 3'd0) && (!head_is32 || count_q >= 3'd2);
  assign consume   = !raw_valid ? 2'd0 : (head_is32 ? 2'd2 : 2'd1);
  assign remaining = count_q - {1'b0, consume};
  assign count_d   = remaining + (fetch_valid ? 3'd2 : 3'd0);

  assign fetch_stall = (int'(count_q) >= stall_level);

  always_comb begin
    raw.bits       = head_is32 ? {buf_q[1], buf_q[0]} : {16'h0000, buf_q[0]};
    raw.pc         = pc_q;
    raw.compressed = !head_is32;
  end

  // Drop consumed parcels and append the new word behind the rest
  always_comb begin
    for (int i = 0; i < buf_halfwords; i++) begin
      if (fetch_valid && i == int'(remaining)) begin
        buf_d[i] = fetch_word[15:0];
      end else if (fetch_valid && i == int'(remaining) + 1) begin
        buf_d[i] = fetch_word[31:16];
      end else if (i + int'(consume) < buf_halfwords) begin
        buf_d[i] = buf_q[i + int'(consume)];
      end else begin
        buf_d[i] = buf_q[i];
      end
    end
  end

  // Entries above count_q are don't care
  always_ff @(posedge clk) begin
    buf_q <= buf_d;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count_q <= 3'd0;
      pc_q    <= reset_pc;
    end else begin
      count_q <= count_d;
      pc_q    <= pc_q + pc_t'({consume, 1'b0});
    end
  end

  // Fill level stays within the buffer across cycles
  a_count_bound: assert property (@(posedge clk) disable iff (!arst_n)
    int'(count_q) <= buf_halfwords)
    else $error("aligner count %0d exceeds buffer", count_q);

  // Source must honour the stall level
  a_stall_obeyed: assert property (@(posedge clk) disable iff (!arst_n)
    !(fetch_valid && fetch_stall))
    else $error("fetch_valid while fetch_stall");

  // An empty buffer with nothing arriving stays empty
  a_valid_nonempty: assert property (@(posedge clk) disable iff (!arst_n)
    count_q == 3'd0 && !fetch_valid |=> !raw_valid)
    else $error("raw_valid with empty buffer");

endmodule

// ==== hw/fetch_frontend.sv ====
// Top of the fetch front end, aligns parcels, expands RVC and issues one instruction per cycle
`timescale 1ns/1ps

module fetch_frontend (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           fetch_valid,
  input  common::word_t  fetch_word,
  output logic           fetch_stall,
  output logic           issue_valid,
  output common::issue_t issue
);
  import common::*;

  logic            raw_valid;
  raw_instr_t      raw;
  instruction_type expanded;
  instruction_type instr_sel;
  // Set once the first instruction has gone out
  logic            issued_q;

  fetch_aligner u_aligner (
    .clk         (clk),
    .arst_n      (arst_n),
    .fetch_valid (fetch_valid),
    .fetch_word  (fetch_word),
    .fetch_stall (fetch_stall),
    .raw_valid   (raw_valid),
    .raw         (raw)
  );

  decompressor u_decomp (
    .cinstr   (raw.bits[15:0]),
    .expanded (expanded)
  );

  // Full width instructions pass untouched
  assign instr_sel = raw.compressed ? expanded : instruction_type'(raw.bits);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      issue_valid <= 1'b0;
      issued_q    <= 1'b0;
    end else begin
      issue_valid <= raw_valid;
      issued_q    <= issued_q | raw_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (raw_valid) begin
      issue <= '{instr: instr_sel, pc: raw.pc, compressed: raw.compressed};
    end
  end

  // Next PC from the aligner continues from the last issued instruction
  a_pc_step: assert property (@(posedge clk) disable iff (!arst_n)
    raw_valid && issued_q |-> raw.pc == issue.pc + (issue.compressed ? pc_t'(2) : pc_t'(4)))
    else $error("PC step broken after %h", issue.pc);

endmodule

// ==== tb.f ====
hw/common.sv
hw/decompressor.sv
hw/fetch_aligner.sv
hw/fetch_frontend.sv
bench/fetch_checker.sv
bench/tb_fetch_frontend.sv
